// File: hw/isa_pkg.sv
// RV32I encodings and the word, address and register-select types shared by the core
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes of the supported subset
    localparam opcode_t OP_IMM = 7'b0010011;
    localparam opcode_t OP     = 7'b0110011;
    localparam opcode_t LOAD   = 7'b0000011;
    localparam opcode_t STORE  = 7'b0100011;
    localparam opcode_t BRANCH = 7'b1100011;
    localparam opcode_t LUI    = 7'b0110111;
    localparam opcode_t AUIPC  = 7'b0010111;
    localparam opcode_t JAL    = 7'b1101111;
    localparam opcode_t JALR   = 7'b1100111;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of the branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // instruction bit inside funct7 that turns ADD into SUB and SRL into SRA
    localparam int FUNCT7_ALT = 30;

endpackage

// File: hw/core_pkg.sv
// control state and ALU operation encodings passed between decode, ALU and control
package core_pkg;

    typedef enum logic [1:0] {
        FETCH,
        WAIT_INSTR,
        WAIT_DATA,
        HALTED
    } ctrl_state_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_t;

endpackage

// File: hw/reg_file.sv
// integer register array, two combinational read ports and one write port, x0 reads zero
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_sel_t rs1_sel,
    input  reg_sel_t rs2_sel,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  reg_sel_t wr_sel,
    input  word_t    wr_data,
    input  logic     wr_en
);
    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // x0 is hardwired, whatever the array holds
    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    a_wr_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wr_en));

endmodule

// File: hw/instr_decode.sv
// splits an instruction into fields, sign-extended immediates and the ALU operation
`timescale 1ns/1ps

module instr_decode import isa_pkg::*, core_pkg::*; (
    input  instr_t     instr,
    output opcode_t    opcode,
    output reg_sel_t   rd_sel,
    output reg_sel_t   rs1_sel,
    output reg_sel_t   rs2_sel,
    output logic [2:0] funct3,
    output word_t      imm_i,
    output word_t      imm_s,
    output word_t      imm_b,
    output word_t      imm_u,
    output word_t      imm_j,
    output alu_op_t    alu_op
);
    logic alt;

    assign opcode  = instr[6:0];
    assign rd_sel  = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];
    assign alt     = instr[FUNCT7_ALT];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // loads, stores and jalr fall through to ADD for address generation
    always_comb begin
        alu_op = ADD;
        if (opcode == OP || opcode == OP_IMM) begin
            case (funct3)
                // addi has no subtract form, the alt bit is part of the immediate there
                F3_ADD:  alu_op = (opcode == OP && alt) ? SUB : ADD;
                F3_SLL:  alu_op = SLL;
                F3_SLT:  alu_op = SLT;
                F3_SLTU: alu_op = SLTU;
                F3_XOR:  alu_op = XOR;
                F3_SR:   alu_op = alt ? SRA : SRL;
                F3_OR:   alu_op = OR;
                F3_AND:  alu_op = AND;
                default: alu_op = ADD;
            endcase
        end
    end

endmodule

// File: hw/alu.sv
// integer operations for OP and OP-IMM, plus the branch condition on the same operands
`timescale 1ns/1ps

module alu import isa_pkg::*, core_pkg::*; (
    input  alu_op_t    alu_op,
    input  word_t      a,
    input  word_t      b,
    output word_t      result,
    input  logic [2:0] funct3,
    output logic       taken
);
    logic       lt_s;
    logic       lt_u;
    logic [4:0] shamt;

    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, lt_s};
            SLTU:    result = {31'b0, lt_u};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // only meaningful while a branch is executing
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (a == b);
            F3_BNE:  taken = (a != b);
            F3_BLT:  taken = lt_s;
            F3_BGE:  taken = !lt_s;
            F3_BLTU: taken = lt_u;
            F3_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: hw/core_ctrl.sv
// multicycle control: pc, memory requests, writeback select, output port and halt
`timescale 1ns/1ps

module core_ctrl import isa_pkg::*, core_pkg::*; #(
    parameter addr_t OUT_ADDR  = 32'd1000,
    parameter addr_t HALT_ADDR = 32'd1004,
    parameter addr_t RESET_PC  = 32'd0
) (
    input  logic     clk,
    input  logic     rst,
    output addr_t    mem_addr,
    output word_t    mem_wr_data,
    output logic     mem_rd_req,
    output logic     mem_wr_req,
    input  word_t    mem_rd_data,
    input  logic     mem_ack,
    output instr_t   instr,
    input  opcode_t  opcode,
    input  reg_sel_t rd_sel,
    input  word_t    imm_i,
    input  word_t    imm_s,
    input  word_t    imm_b,
    input  word_t    imm_u,
    input  word_t    imm_j,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output word_t    alu_a,
    output word_t    alu_b,
    input  word_t    alu_result,
    input  logic     taken,
    output reg_sel_t wr_sel,
    output word_t    wr_data,
    output logic     wr_en,
    output word_t    out,
    output logic     out_en,
    output logic     halt
);
    ctrl_state_t state;
    ctrl_state_t next_state;
    addr_t       pc;
    addr_t       next_pc;
    addr_t       pc_plus4;
    instr_t      instr_q;
    logic        rd_req_d;
    logic        wr_req_d;
    logic        data_req;
    logic        out_en_d;

    assign pc_plus4 = pc + 32'd4;

    // the instruction is taken straight off the bus in its ack cycle
    assign instr = (state == WAIT_DATA) ? instr_q : mem_rd_data;

    assign alu_a = rs1_data;
    always_comb begin
        case (opcode)
            OP, BRANCH: alu_b = rs2_data;
            STORE:      alu_b = imm_s;
            default:    alu_b = imm_i;
        endcase
    end

    assign wr_sel = rd_sel;
    always_comb begin
        case (opcode)
            LUI:       wr_data = imm_u;
            AUIPC:     wr_data = pc + imm_u;
            JAL, JALR: wr_data = pc_plus4;
            LOAD:      wr_data = mem_rd_data;
            default:   wr_data = alu_result;
        endcase
    end

    always_comb begin
        next_state = state;
        next_pc    = pc;
        rd_req_d   = 1'b0;
        wr_req_d   = 1'b0;
        data_req   = 1'b0;
        out_en_d   = 1'b0;
        wr_en      = 1'b0;
        case (state)
            FETCH: begin
                rd_req_d   = 1'b1;
                next_state = WAIT_INSTR;
            end
            WAIT_INSTR: begin
                if (mem_ack) begin
                    rd_req_d = 1'b1;
                    next_pc  = pc_plus4;
                    case (opcode)
                        OP_IMM, OP, LUI, AUIPC: wr_en = 1'b1;
                        BRANCH: begin
                            if (taken) begin
                                next_pc = pc + imm_b;
                            end
                        end
                        JAL: begin
                            wr_en   = 1'b1;
                            next_pc = pc + imm_j;
                        end
                        JALR: begin
                            wr_en   = 1'b1;
                            next_pc = {alu_result[31:1], 1'b0};
                        end
                        LOAD: begin
                            data_req = 1'b1;
                        end
                        STORE: begin
                            if (alu_result == OUT_ADDR) begin
                                out_en_d = 1'b1;
                            end else if (alu_result == HALT_ADDR) begin
                                rd_req_d   = 1'b0;
                                next_state = HALTED;
                            end else begin
                                data_req = 1'b1;
                            end
                        end
                        default: begin
                            rd_req_d   = 1'b0;
                            next_state = HALTED;
                        end
                    endcase
                    // a data access keeps pc on the current instruction until it completes
                    if (data_req) begin
                        rd_req_d   = (opcode == LOAD);
                        wr_req_d   = (opcode == STORE);
                        next_pc    = pc;
                        next_state = WAIT_DATA;
                    end
                end
            end
            WAIT_DATA: begin
                if (mem_ack) begin
                    wr_en      = (opcode == LOAD);
                    rd_req_d   = 1'b1;
                    next_pc    = pc_plus4;
                    next_state = WAIT_INSTR;
                end
            end
            default: begin
                next_state = HALTED;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FETCH;
            pc         <= RESET_PC;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            out_en     <= 1'b0;
        end else begin
            state      <= next_state;
            pc         <= next_pc;
            mem_rd_req <= rd_req_d;
            mem_wr_req <= wr_req_d;
            out_en     <= out_en_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req_d || wr_req_d) begin
            mem_addr <= data_req ? alu_result : next_pc;
        end
        if (wr_req_d) begin
            mem_wr_data <= rs2_data;
        end
        if (data_req) begin
            instr_q <= mem_rd_data;
        end
        if (out_en_d) begin
            out <= rs2_data;
        end
    end

    assign halt = (state == HALTED);

    a_one_request: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req && mem_wr_req));
    a_state_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(state));
    a_halted_quiet: assert property (@(posedge clk) disable iff (rst)
        state == HALTED |-> !mem_rd_req && !mem_wr_req);

endmodule

// File: hw/proc_top.sv
// RV32I core top level joining register file, decode, ALU and control to one memory port
`timescale 1ns/1ps

module proc_top import isa_pkg::*, core_pkg::*; #(
    parameter addr_t OUT_ADDR  = 32'd1000,
    parameter addr_t HALT_ADDR = 32'd1004,
    parameter addr_t RESET_PC  = 32'd0
) (
    input  logic  clk,
    input  logic  rst,
    output addr_t mem_addr,
    output word_t mem_wr_data,
    output logic  mem_rd_req,
    output logic  mem_wr_req,
    input  word_t mem_rd_data,
    input  logic  mem_ack,
    output word_t out,
    output logic  out_en,
    output logic  halt
);
    instr_t     instr;
    opcode_t    opcode;
    reg_sel_t   rd_sel;
    reg_sel_t   rs1_sel;
    reg_sel_t   rs2_sel;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    alu_op;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic       taken;
    reg_sel_t   wr_sel;
    word_t      wr_data;
    logic       wr_en;

    reg_file u_reg_file (
        .clk(clk), .rst(rst),
        .rs1_sel(rs1_sel), .rs2_sel(rs2_sel),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_sel(wr_sel), .wr_data(wr_data), .wr_en(wr_en)
    );

    instr_decode u_decode (
        .instr(instr), .opcode(opcode),
        .rd_sel(rd_sel), .rs1_sel(rs1_sel), .rs2_sel(rs2_sel), .funct3(funct3),
        .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b), .imm_u(imm_u), .imm_j(imm_j),
        .alu_op(alu_op)
    );

    alu u_alu (
        .alu_op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .funct3(funct3), .taken(taken)
    );

    core_ctrl #(
        .OUT_ADDR(OUT_ADDR), .HALT_ADDR(HALT_ADDR), .RESET_PC(RESET_PC)
    ) u_ctrl (
        .clk(clk), .rst(rst),
        .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .mem_rd_data(mem_rd_data), .mem_ack(mem_ack),
        .instr(instr), .opcode(opcode), .rd_sel(rd_sel),
        .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b), .imm_u(imm_u), .imm_j(imm_j),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result), .taken(taken),
        .wr_sel(wr_sel), .wr_data(wr_data), .wr_en(wr_en),
        .out(out), .out_en(out_en), .halt(halt)
    );

endmodule

// File: tb/tb_mem.sv
// word memory model for the testbench, holds the test program and answers after a random delay
`timescale 1ns/1ps

module tb_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wr_data,
    input  logic        mem_rd_req,
    input  logic        mem_wr_req,
    output logic [31:0] mem_rd_data,
    output logic        mem_ack
);
    logic [31:0] words [256];
    logic [31:0] lcg_state;
    logic [31:0] req_addr;
    logic        busy;
    int          count;

    // instruction encoders, one per RV32I format
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // LCG step, returns an ack delay of 1 to 4 cycles
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return 1 + int'(lcg_state[17:16]);
    endfunction

    initial begin
        lcg_state   = 32'd3;
        mem_rd_data = '0;
        mem_ack     = 1'b0;
        busy        = 1'b0;
        count       = 0;
        req_addr    = '0;
        for (int i = 0; i < 256; i++) begin
            words[i] = 32'hA5A5_0000 ^ (i * 4);
        end
        // operand setup
        words[0]  = enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);      // addi x1,x0,5
        words[1]  = enc_i(12'hFFD, 5'd0, 3'b000, 5'd2, 7'b0010011);    // addi x2,x0,-3
        words[2]  = {20'h12345, 5'd3, 7'b0110111};                     // lui x3
        words[3]  = {20'h00001, 5'd4, 7'b0010111};                     // auipc x4
        words[4]  = enc_s(12'd1000, 5'd3, 5'd0);
        words[5]  = enc_s(12'd1000, 5'd4, 5'd0);
        // arithmetic and logic
        words[6]  = enc_r(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd5);       // sub
        words[7]  = enc_s(12'd1000, 5'd5, 5'd0);
        words[8]  = enc_r(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd6);       // slt
        words[9]  = enc_s(12'd1000, 5'd6, 5'd0);
        words[10] = enc_r(7'b0000000, 5'd1, 5'd2, 3'b011, 5'd7);       // sltu
        words[11] = enc_s(12'd1000, 5'd7, 5'd0);
        words[12] = enc_r(7'b0100000, 5'd1, 5'd2, 3'b101, 5'd8);       // sra
        words[13] = enc_s(12'd1000, 5'd8, 5'd0);
        words[14] = enc_i(12'h401, 5'd2, 3'b101, 5'd9, 7'b0010011);    // srai x9,x2,1
        words[15] = enc_s(12'd1000, 5'd9, 5'd0);
        words[16] = enc_r(7'b0000000, 5'd1, 5'd1, 3'b001, 5'd10);      // sll
        words[17] = enc_s(12'd1000, 5'd10, 5'd0);
        words[18] = enc_i(12'd28, 5'd2, 3'b101, 5'd11, 7'b0010011);    // srli x11,x2,28
        words[19] = enc_s(12'd1000, 5'd11, 5'd0);
        words[20] = enc_r(7'b0000000, 5'd1, 5'd3, 3'b100, 5'd12);      // xor
        words[21] = enc_s(12'd1000, 5'd12, 5'd0);
        words[22] = enc_r(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd13);      // or
        words[23] = enc_s(12'd1000, 5'd13, 5'd0);
        words[24] = enc_i(12'h00F, 5'd12, 3'b111, 5'd14, 7'b0010011);  // andi
        words[25] = enc_s(12'd1000, 5'd14, 5'd0);
        // store then load back through data address 0x200
        words[26] = enc_s(12'h200, 5'd12, 5'd0);
        words[27] = enc_i(12'h200, 5'd0, 3'b010, 5'd15, 7'b0000011);   // lw x15
        words[28] = enc_s(12'd1000, 5'd15, 5'd0);
        // countdown loop 3, 2, 1
        words[29] = enc_i(12'd3, 5'd0, 3'b000, 5'd16, 7'b0010011);
        words[30] = enc_s(12'd1000, 5'd16, 5'd0);
        words[31] = enc_i(12'hFFF, 5'd16, 3'b000, 5'd16, 7'b0010011);
        words[32] = enc_b(13'h1FF8, 5'd0, 5'd16, 3'b001);              // bne back to 30
        words[33] = enc_b(13'd8, 5'd1, 5'd2, 3'b100);                  // blt skips 34
        words[34] = enc_s(12'd1000, 5'd1, 5'd0);
        words[35] = enc_j(21'd16, 5'd17);                              // jal x17 to 39
        words[36] = enc_i(12'h5A5, 5'd0, 3'b000, 5'd19, 7'b0010011);
        words[37] = enc_s(12'd1000, 5'd19, 5'd0);
        words[38] = enc_s(12'd1004, 5'd0, 5'd0);                       // halt
        words[39] = enc_s(12'd1000, 5'd17, 5'd0);
        words[40] = enc_i(12'd0, 5'd17, 3'b000, 5'd0, 7'b1100111);     // jalr x0,0(x17)
    end

    // requests are looked at a little after each rising edge
    initial begin
        forever begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy) begin
                count = count - 1;
                if (count == 0) begin
                    mem_rd_data = words[req_addr[9:2]];
                    mem_ack     = 1'b1;
                    busy        = 1'b0;
                end
            end else if (mem_rd_req || mem_wr_req) begin
                req_addr = mem_addr;
                if (mem_wr_req) begin
                    words[mem_addr[9:2]] = mem_wr_data;
                end
                count = next_delay();
                busy  = 1'b1;
            end
        end
    end

endmodule

// File: tb/tb_proc.sv
// testbench top with clock, reset, core under test, memory model and output checks
`timescale 1ns/1ps

module tb_proc;
    localparam int N_EXP = 18;

    logic        clk;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic        mem_rd_req;
    logic        mem_wr_req;
    logic [31:0] mem_rd_data;
    logic        mem_ack;
    logic [31:0] out;
    logic        out_en;
    logic        halt;
    logic [31:0] expected [N_EXP];
    int          out_idx;
    logic        seen_req;
    int          cycles;

    proc_top DUT (
        .clk(clk), .rst(rst),
        .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .mem_rd_data(mem_rd_data), .mem_ack(mem_ack),
        .out(out), .out_en(out_en), .halt(halt)
    );

    tb_mem u_mem (
        .clk(clk), .rst(rst),
        .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .mem_rd_data(mem_rd_data), .mem_ack(mem_ack)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // output words worked out by hand from the program
    initial begin
        expected[0]  = 32'h1234_5000;
        expected[1]  = 32'h0000_100C;
        expected[2]  = 32'd8;
        expected[3]  = 32'd1;
        expected[4]  = 32'd0;
        expected[5]  = 32'hFFFF_FFFF;
        expected[6]  = 32'hFFFF_FFFE;
        expected[7]  = 32'h0000_00A0;
        expected[8]  = 32'h0000_000F;
        expected[9]  = 32'h1234_5005;
        expected[10] = 32'hFFFF_FFFD;
        expected[11] = 32'd5;
        expected[12] = 32'h1234_5005;
        expected[13] = 32'd3;
        expected[14] = 32'd2;
        expected[15] = 32'd1;
        expected[16] = 32'h0000_0090;
        expected[17] = 32'h0000_05A5;
    end

    always @(posedge clk) begin
        if (rst) begin
            out_idx  <= 0;
            seen_req <= 1'b0;
        end else begin
            if (out_en) begin
                out_idx <= out_idx + 1;
            end
            if (mem_rd_req || mem_wr_req) begin
                seen_req <= 1'b1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        rst |-> !mem_rd_req && !mem_wr_req && !out_en && !halt)
        else stop_with_failure("a request, out_en or halt was active during reset");

    a_release_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !mem_rd_req && !mem_wr_req && !out_en && !halt)
        else stop_with_failure("a request, out_en or halt was active right after reset");

    a_first_fetch: assert property (@(posedge clk) disable iff (rst)
        (!seen_req && (mem_rd_req || mem_wr_req)) |-> mem_rd_req && mem_addr == 32'd0)
        else stop_with_failure("the first request was not a read at address 0");

    a_out_count: assert property (@(posedge clk) disable iff (rst)
        out_en |-> out_idx < N_EXP)
        else stop_with_failure("more output words than expected");

    a_out_value: assert property (@(posedge clk) disable iff (rst)
        (out_en && out_idx < N_EXP) |-> out == expected[out_idx])
        else begin
            $display("error at %0t: out = %h, expected %h", $time, $sampled(out),
                     expected[$sampled(out_idx)]);
            stop_with_failure("output word mismatch");
        end

    a_halt_held: assert property (@(posedge clk) disable iff (rst) $past(halt) |-> halt)
        else stop_with_failure("halt dropped before reset");

    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        halt |-> !mem_rd_req && !mem_wr_req)
        else stop_with_failure("a memory request appeared while halted");

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        cycles = 0;
        while (!halt && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (!halt) begin
            stop_with_failure("timeout: the core never halted");
        end
        // halt must stay high with no requests for 20 cycles
        cycles = 0;
        while (cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (out_idx == N_EXP) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("only %0d of %0d output words were seen", out_idx, N_EXP);
            stop_with_failure("not every expected output word appeared");
        end
    end

endmodule

// File: filelist.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/alu.sv
hw/core_ctrl.sv
hw/proc_top.sv
tb/tb_mem.sv
tb/tb_proc.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_proc -o sim_tb_proc
./obj_dir/sim_tb_proc
